// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_sprite_controller
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the testbench printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// File: bus_pkg.sv
//----------------------------------------------------------------------------
// Host register bus and sprite memory channel types
//  register address, data and write record
//  sprite memory word address and data
//  attribute table select codes
//----------------------------------------------------------------------------

package bus_pkg;

	// Bits 9:8 pick the table, bits 7:0 the sprite
	typedef logic [9:0]  reg_addr_t;
	typedef logic [15:0] reg_data_t;

	typedef struct packed {
		reg_addr_t addr;
		reg_data_t data;
		logic      wr;
	} reg_wr_t;

	typedef logic [15:0] mem_addr_t;
	// Four nibbles, lowest nibble is the leftmost pixel
	typedef logic [15:0] mem_data_t;

	localparam logic [1:0] TABLE_X = 2'd0;
	localparam logic [1:0] TABLE_Y = 2'd1;
	localparam logic [1:0] TABLE_H = 2'd2;
	localparam logic [1:0] TABLE_A = 2'd3;

endpackage

// File: dp_ram.sv
//----------------------------------------------------------------------------
// Simple dual-port block RAM
//  one read port with registered output
//  one synchronous write port
//----------------------------------------------------------------------------

module dp_ram #(
	parameter int DATA_BITS = 16,
	parameter int ADDR_BITS = 8
) (
	input  logic                 CLK,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output logic [DATA_BITS-1:0] rd_data,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  logic [DATA_BITS-1:0] wr_data,
	input  logic                 wr
);

	logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

// File: scanline_buffer.sv
//----------------------------------------------------------------------------
// Double-buffered scanline memory
//  back half takes renderer pixel writes
//  front half is read by the display and cleared behind the read
//  halves swap on each horizontal tick
//----------------------------------------------------------------------------

module scanline_buffer (
	input  logic                CLK,
	input  logic                RSTb,
	input  logic                H_tick,
	input  sprite_pkg::pix_wr_t pix,
	input  sprite_pkg::coord_t  display_x,
	input  logic                re,
	output sprite_pkg::color_t  color_index
);

	// Half written by the renderer
	logic               active;
	// Front half and read strobe of the previous cycle
	logic               front_q;
	logic               re_q;
	sprite_pkg::coord_t x_q;
	sprite_pkg::color_t rd_data [2];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			active  <= 1'b0;
			front_q <= 1'b0;
			re_q    <= 1'b0;
		end else begin
			if (H_tick) begin
				active <= ~active;
			end
			front_q <= ~active;
			re_q    <= re;
		end
	end

	always_ff @(posedge CLK) begin
		x_q <= display_x;
	end

	for (genvar h = 0; h < 2; h++) begin : g_half
		logic               clr;
		logic               wr;
		sprite_pkg::coord_t wr_addr;
		sprite_pkg::color_t wr_data;

		// Clear the entry read one cycle ago
		assign clr     = re_q && (front_q == 1'(h));
		assign wr      = clr || (pix.we && (active == 1'(h)));
		assign wr_addr = clr ? x_q : pix.x;
		assign wr_data = clr ? '0 : pix.color;

		dp_ram #(
			.DATA_BITS($bits(sprite_pkg::color_t)),
			.ADDR_BITS($bits(sprite_pkg::coord_t))
		) i_line_ram (
			.CLK     (CLK),
			.rd_addr (display_x),
			.rd_data (rd_data[h]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.wr      (wr)
		);
	end

	assign color_index = rd_data[front_q];

endmodule

// File: sim.f
sprite_pkg.sv
bus_pkg.sv
dp_ram.sv
sprite_attr_table.sv
scanline_buffer.sv
sprite_renderer.sv
sprite_controller.sv
tb_sprite_controller.sv

// File: sprite_attr_table.sv
//----------------------------------------------------------------------------
// Sprite attribute tables
//  X, Y, H and A word RAMs written by the host
//  read by sprite index, one cycle latency
//  assembly of the four words into one attribute record
//----------------------------------------------------------------------------

module sprite_attr_table #(
	parameter int SPRITE_INDEX_BITS = 8
) (
	input  logic                         CLK,
	input  bus_pkg::reg_wr_t             host,
	input  logic [SPRITE_INDEX_BITS-1:0] sprite_idx,
	output sprite_pkg::sprite_attr_t     attr
);

	logic [3:0]         tbl_wr;
	bus_pkg::reg_data_t tbl_word [4];
	bus_pkg::reg_data_t x_word;
	bus_pkg::reg_data_t y_word;
	bus_pkg::reg_data_t h_word;
	bus_pkg::reg_data_t a_word;

	// One RAM per table, loop index is the table code
	for (genvar i = 0; i < 4; i++) begin : g_table
		assign tbl_wr[i] = host.wr && (host.addr[9:8] == 2'(i));

		dp_ram #(
			.DATA_BITS($bits(bus_pkg::reg_data_t)),
			.ADDR_BITS(SPRITE_INDEX_BITS)
		) i_ram (
			.CLK     (CLK),
			.rd_addr (sprite_idx),
			.rd_data (tbl_word[i]),
			.wr_addr (host.addr[SPRITE_INDEX_BITS-1:0]),
			.wr_data (host.data),
			.wr      (tbl_wr[i])
		);
	end

	assign x_word = tbl_word[bus_pkg::TABLE_X];
	assign y_word = tbl_word[bus_pkg::TABLE_Y];
	assign h_word = tbl_word[bus_pkg::TABLE_H];
	assign a_word = tbl_word[bus_pkg::TABLE_A];

	always_comb begin
		attr.x        = x_word[9:0];
		attr.en       = x_word[10];
		attr.pal      = x_word[14:11];
		attr.stride   = x_word[15];
		attr.y_start  = y_word[9:0];
		attr.width    = y_word[15:10];
		attr.y_end    = h_word[9:0];
		attr.base     = a_word;
		// Upper H bits carried along unused
		attr.reserved = h_word[15:10];
	end

endmodule

// File: sprite_controller.sv
//----------------------------------------------------------------------------
// Scanline sprite engine top level
//  host attribute table writes
//  line renderer with sprite memory read channel
//  double-buffered scanline read by the display
//----------------------------------------------------------------------------

module sprite_controller #(
	parameter int SPRITE_INDEX_BITS = 8
) (
	input  logic               CLK,
	input  logic               RSTb,
	input  bus_pkg::reg_addr_t ADDRESS,
	input  bus_pkg::reg_data_t DATA_IN,
	input  logic               WR,
	input  logic               H_tick,
	input  sprite_pkg::coord_t display_x,
	input  sprite_pkg::coord_t display_y,
	input  logic               re,
	output sprite_pkg::color_t color_index,
	output bus_pkg::mem_addr_t memory_address,
	input  bus_pkg::mem_data_t memory_data,
	output logic               rvalid,
	input  logic               rready
);

	bus_pkg::reg_wr_t             host;
	logic [SPRITE_INDEX_BITS-1:0] sprite_idx;
	sprite_pkg::sprite_attr_t     attr;
	sprite_pkg::pix_wr_t          pix;

	assign host = '{addr: ADDRESS, data: DATA_IN, wr: WR};

	sprite_attr_table #(
		.SPRITE_INDEX_BITS(SPRITE_INDEX_BITS)
	) i_attr_table (
		.CLK        (CLK),
		.host       (host),
		.sprite_idx (sprite_idx),
		.attr       (attr)
	);

	sprite_renderer #(
		.SPRITE_INDEX_BITS(SPRITE_INDEX_BITS)
	) i_renderer (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.H_tick         (H_tick),
		.display_y      (display_y),
		.sprite_idx     (sprite_idx),
		.attr           (attr),
		.memory_address (memory_address),
		.memory_data    (memory_data),
		.rvalid         (rvalid),
		.rready         (rready),
		.pix            (pix)
	);

	scanline_buffer i_scanline (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.H_tick      (H_tick),
		.pix         (pix),
		.display_x   (display_x),
		.re          (re),
		.color_index (color_index)
	);

endmodule

// File: sprite_pkg.sv
//----------------------------------------------------------------------------
// Sprite engine types
//  pixel, color, coordinate and sheet address widths
//  per-sprite attribute record assembled from the four tables
//  single pixel write into the scanline buffer
//----------------------------------------------------------------------------

package sprite_pkg;

	typedef logic [9:0]  coord_t;
	// Value 0 is transparent
	typedef logic [3:0]  nibble_t;
	typedef logic [3:0]  palette_t;
	// Palette high in the upper nibble, pixel in the lower
	typedef logic [7:0]  color_t;
	// Sprite width minus one
	typedef logic [5:0]  width_t;
	typedef logic [17:0] nibble_addr_t;

	typedef struct packed {
		coord_t      x;
		logic        en;
		palette_t    pal;
		logic        stride;	// 0: 320 nibbles per row, 1: 256
		coord_t      y_start;
		width_t      width;
		coord_t      y_end;
		logic [15:0] base;	// Sheet word address
		logic [5:0]  reserved;
	} sprite_attr_t;

	typedef struct packed {
		coord_t x;
		color_t color;
		logic   we;
	} pix_wr_t;

endpackage

// File: sprite_renderer.sv
//----------------------------------------------------------------------------
// Sprite line renderer
//  walks all sprites on each horizontal tick
//  line hit test and sheet nibble address computation
//  sprite memory fetch over the rvalid/rready channel
//  blit of opaque nibbles into the scanline buffer
//----------------------------------------------------------------------------

module sprite_renderer #(
	parameter int SPRITE_INDEX_BITS = 8
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic                         H_tick,
	input  sprite_pkg::coord_t           display_y,
	output logic [SPRITE_INDEX_BITS-1:0] sprite_idx,
	input  sprite_pkg::sprite_attr_t     attr,
	output bus_pkg::mem_addr_t           memory_address,
	input  bus_pkg::mem_data_t           memory_data,
	output logic                         rvalid,
	input  logic                         rready,
	output sprite_pkg::pix_wr_t          pix
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_BEGIN,
		S_HIT,
		S_ADDR,
		S_FETCH,
		S_BLIT0,
		S_BLIT1,
		S_BLIT2,
		S_BLIT3,
		S_NEXT
	} state_t;

	state_t                   state;
	state_t                   blit_next;
	sprite_pkg::coord_t       line_y;
	sprite_pkg::coord_t       pix_x;
	sprite_pkg::coord_t       v;
	sprite_pkg::coord_t       hit_v;
	sprite_pkg::width_t       u;
	sprite_pkg::width_t       width;
	sprite_pkg::palette_t     pal;
	sprite_pkg::nibble_t      nib;
	sprite_pkg::nibble_addr_t row_off;
	sprite_pkg::nibble_addr_t fetch_addr;
	bus_pkg::mem_data_t       data_q;
	logic                     hit;
	logic                     last_sprite;

	assign hit = attr.en && (line_y >= attr.y_start) && (line_y <= attr.y_end);
	assign hit_v = line_y - attr.y_start;
	assign last_sprite = (sprite_idx == '1);

	// Row offset is v * 256, plus v * 64 for the 320 nibble stride
	always_comb begin
		row_off = {v, 8'd0};
		if (!attr.stride) begin
			row_off = row_off + {2'b00, v, 6'd0};
		end
		fetch_addr = {attr.base, 2'b00} + row_off + sprite_pkg::nibble_addr_t'(u);
	end

	// Nibble for the current blit state, zero outside blits
	always_comb begin
		nib       = '0;
		blit_next = S_ADDR;
		case (state)
			S_BLIT0: begin
				nib       = data_q[3:0];
				blit_next = S_BLIT1;
			end
			S_BLIT1: begin
				nib       = data_q[7:4];
				blit_next = S_BLIT2;
			end
			S_BLIT2: begin
				nib       = data_q[11:8];
				blit_next = S_BLIT3;
			end
			S_BLIT3: begin
				nib       = data_q[15:12];
				blit_next = S_ADDR;
			end
			default: ;
		endcase
		pix.x     = pix_x;
		pix.color = {pal, nib};
		pix.we    = (nib != '0);
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state      <= S_IDLE;
			sprite_idx <= '0;
			rvalid     <= 1'b0;
		end else if (H_tick) begin
			// New line, abandon whatever is left
			state      <= S_BEGIN;
			sprite_idx <= '0;
			rvalid     <= 1'b0;
			line_y     <= display_y;
		end else begin
			case (state)
				S_IDLE: ;
				// Attribute read in flight
				S_BEGIN: state <= S_HIT;
				S_HIT: begin
					if (hit) begin
						pix_x <= attr.x;
						u     <= '0;
						v     <= hit_v;
						pal   <= attr.pal;
						width <= attr.width;
						state <= S_ADDR;
					end else if (last_sprite) begin
						state <= S_IDLE;
					end else begin
						sprite_idx <= sprite_idx + 1'b1;
						state      <= S_BEGIN;
					end
				end
				S_ADDR: begin
					memory_address <= fetch_addr[17:2];
					rvalid         <= 1'b1;
					state          <= S_FETCH;
				end
				S_FETCH: begin
					if (rready) begin
						data_q <= memory_data;
						rvalid <= 1'b0;
						state  <= S_BLIT0;
					end
				end
				S_BLIT0, S_BLIT1, S_BLIT2, S_BLIT3: begin
					pix_x <= pix_x + 1'b1;
					u     <= u + 1'b1;
					if (u == width) begin
						state <= S_NEXT;
					end else begin
						state <= blit_next;
					end
				end
				S_NEXT: begin
					if (last_sprite) begin
						state <= S_IDLE;
					end else begin
						sprite_idx <= sprite_idx + 1'b1;
						state      <= S_BEGIN;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: tb_sprite_controller.sv
//----------------------------------------------------------------------------
// Testbench for the scanline sprite engine
//  clock, reset, LFSR and sprite memory model with rready delays
//  reference line computed from a copy of the tables and memory
//  line schedule with one line of latency between render and readback
//  compare tasks, cycle limit
//----------------------------------------------------------------------------

module tb_sprite_controller;

	localparam int LINE_CYCLES   = 1200;
	localparam int LINE_PIXELS   = 800;
	localparam int MAX_CYCLES    = 16 * LINE_CYCLES + 1000;
	localparam int N_SPRITES     = 256;
	localparam int CHECKED_LINES = 12;

	logic               CLK;
	logic               RSTb;
	bus_pkg::reg_addr_t ADDRESS;
	bus_pkg::reg_data_t DATA_IN;
	logic               WR;
	logic               H_tick;
	sprite_pkg::coord_t display_x;
	sprite_pkg::coord_t display_y;
	logic               re;
	sprite_pkg::color_t color_index;
	bus_pkg::mem_addr_t memory_address;
	bus_pkg::mem_data_t memory_data = '0;
	logic               rvalid;
	logic               rready = 1'b0;

	// Copy of the attribute tables and the sprite sheet
	bus_pkg::reg_data_t tbl [4][N_SPRITES];
	bus_pkg::mem_data_t mem [65536];
	sprite_pkg::color_t next_line [1024];
	sprite_pkg::color_t shown_line [1024];
	string              next_name = "";
	string              shown_name = "";
	logic               next_valid = 1'b0;
	logic               shown_valid = 1'b0;
	logic [31:0]        lfsr = 32'h72a7d03f;
	logic               rand_delay = 1'b0;
	int                 cycle = 0;
	int                 n_checked = 0;

	sprite_controller i_dut (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.ADDRESS        (ADDRESS),
		.DATA_IN        (DATA_IN),
		.WR             (WR),
		.H_tick         (H_tick),
		.display_x      (display_x),
		.display_y      (display_y),
		.re             (re),
		.color_index    (color_index),
		.memory_address (memory_address),
		.memory_data    (memory_data),
		.rvalid         (rvalid),
		.rready         (rready)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r    = {r[14:0], lfsr[0]};
		end
		return r;
	endfunction

	// Expected line with later sprites drawn over earlier ones
	function automatic void render_ref(input sprite_pkg::coord_t y);
		bus_pkg::reg_data_t xw;
		bus_pkg::reg_data_t yw;
		bus_pkg::reg_data_t hw;
		logic [17:0]        na;
		logic [9:0]         px;
		logic [3:0]         nib;
		int                 v;
		int                 row;
		for (int i = 0; i < 1024; i++) begin
			next_line[i] = '0;
		end
		for (int s = 0; s < N_SPRITES; s++) begin
			xw = tbl[bus_pkg::TABLE_X][s];
			yw = tbl[bus_pkg::TABLE_Y][s];
			hw = tbl[bus_pkg::TABLE_H][s];
			if (xw[10] && y >= yw[9:0] && y <= hw[9:0]) begin
				v   = int'(y) - int'(yw[9:0]);
				row = xw[15] ? 256 : 320;
				for (int u = 0; u <= int'(yw[15:10]); u++) begin
					na  = 18'(int'(tbl[bus_pkg::TABLE_A][s]) * 4 + v * row + u);
					nib = 4'(mem[na[17:2]] >> (4 * na[1:0]));
					px  = 10'(int'(xw[9:0]) + u);
					if (nib != 4'd0) begin
						next_line[px] = {xw[14:11], nib};
					end
				end
			end
		end
	endfunction

	task automatic check_color(input string name, input sprite_pkg::coord_t x,
		input sprite_pkg::color_t expected, input sprite_pkg::color_t actual);
		n_checked++;
		if (actual !== expected) begin
			$display("FAIL %s x=%0d expected %h actual %h", name, x, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Scanline color mismatch");
		end
	endtask

	task automatic check_idle(input string name);
		if (rvalid !== 1'b0) begin
			$display("FAIL %s rvalid expected 0 actual %b", name, rvalid);
			$display("=== FAIL ===");
			$fatal(1, "Memory request still open");
		end
	endtask

	task automatic write_reg(input logic [1:0] sel, input int idx, input bus_pkg::reg_data_t data);
		ADDRESS       = {sel, 8'(idx)};
		DATA_IN       = data;
		WR            = 1'b1;
		tbl[sel][idx] = data;
		@(negedge CLK);
		WR = 1'b0;
	endtask

	task automatic set_sprite(input int idx, input int x, input int pal, input logic stride,
		input int y0, input int w, input int y1, input int base);
		write_reg(bus_pkg::TABLE_X, idx, {stride, 4'(pal), 1'b1, 10'(x)});
		write_reg(bus_pkg::TABLE_Y, idx, {6'(w), 10'(y0)});
		write_reg(bus_pkg::TABLE_H, idx, 16'(y1));
		write_reg(bus_pkg::TABLE_A, idx, 16'(base));
	endtask

	task automatic shape_words(input int base, input int n, input bus_pkg::mem_data_t keep,
		input bus_pkg::mem_data_t set_bits);
		for (int a = base; a < base + n; a++) begin
			mem[a] = (mem[a] & keep) | set_bits;
		end
	endtask

	// One line period of a tick, 800 reads of the previous line and an idle tail
	task automatic run_line(input string name, input int y);
		check_idle(name);
		display_y   = 10'(y);
		H_tick      = 1'b1;
		shown_line  = next_line;
		shown_name  = next_name;
		shown_valid = next_valid;
		render_ref(10'(y));
		next_name   = name;
		next_valid  = 1'b1;
		@(negedge CLK);
		H_tick = 1'b0;
		for (int x = 0; x < LINE_PIXELS; x++) begin
			display_x = 10'(x);
			re        = 1'b1;
			@(negedge CLK);
		end
		re = 1'b0;
		repeat (LINE_CYCLES - LINE_PIXELS - 1) @(negedge CLK);
	endtask

	// Sprite memory model with random rready delays
	initial begin
		logic               busy;
		bus_pkg::mem_addr_t held_addr;
		int                 wait_cnt;
		busy      = 1'b0;
		held_addr = '0;
		wait_cnt  = 0;
		forever begin
			@(negedge CLK);
			if (rvalid !== 1'b1) begin
				busy   = 1'b0;
				rready = 1'b0;
			end else if (busy && memory_address != held_addr) begin
				$display("Sprite memory address moved from %h to %h before rready",
					held_addr, memory_address);
				$display("=== FAIL ===");
				$fatal(1, "Memory channel protocol error");
			end else begin
				if (!busy) begin
					busy      = 1'b1;
					held_addr = memory_address;
					wait_cnt  = rand_delay ? int'(rand_bits(2)) : 0;
				end
				if (wait_cnt == 0) begin
					rready      = 1'b1;
					memory_data = mem[memory_address];
				end else begin
					rready = 1'b0;
					wait_cnt--;
				end
			end
		end
	end

	// Color is valid one cycle after the read
	initial begin
		logic               chk_pend;
		sprite_pkg::coord_t chk_x;
		forever begin
			@(posedge CLK);
			chk_pend = re && shown_valid;
			chk_x    = display_x;
			@(negedge CLK);
			if (chk_pend) begin
				check_color(shown_name, chk_x, shown_line[chk_x], color_index);
			end
		end
	end

	initial begin
		forever begin
			@(posedge CLK);
			cycle++;
			if (cycle >= MAX_CYCLES) begin
				$display("Run did not finish within %0d cycles", MAX_CYCLES);
				$display("=== FAIL ===");
				$fatal(1, "Timeout");
			end
		end
	end

	initial begin
		RSTb      = 1'b0;
		ADDRESS   = '0;
		DATA_IN   = '0;
		WR        = 1'b0;
		H_tick    = 1'b0;
		display_x = '0;
		display_y = '0;
		re        = 1'b0;
		for (int a = 0; a < 65536; a++) begin
			mem[a] = rand_bits(16);
		end
		repeat (5) @(negedge CLK);
		RSTb = 1'b1;
		// Clear all table words so every sprite is off
		for (int s = 0; s < N_SPRITES; s++) begin
			for (int t = 0; t < 4; t++) begin
				write_reg(2'(t), s, '0);
			end
		end
		// Front half left over from power-up
		for (int x = 0; x < LINE_PIXELS; x++) begin
			display_x = 10'(x);
			re        = 1'b1;
			@(negedge CLK);
		end
		re = 1'b0;
		@(negedge CLK);

		run_line("all_disabled", 50);
		shape_words(16'h0400, 8, 16'hffff, 16'h1111);
		set_sprite(3, 100, 5, 1'b0, 60, 31, 60, 16'h0400);
		run_line("single_opaque", 60);
		// Zero nibbles 0 and 2 of every word let sprite 3 through
		shape_words(16'h2000, 6, 16'hf0f0, 16'h1010);
		set_sprite(200, 120, 9, 1'b1, 60, 23, 60, 16'h2000);
		run_line("overlap", 60);
		write_reg(bus_pkg::TABLE_X, 200, '0);
		set_sprite(3, 200, 6, 1'b0, 300, 15, 340, 16'h0800);
		run_line("above_range", 299);
		run_line("below_range", 341);
		run_line("stride_320", 317);
		set_sprite(3, 200, 6, 1'b1, 300, 15, 340, 16'h0800);
		// Sheet address wraps past the top of memory
		set_sprite(255, 700, 12, 1'b0, 330, 63, 340, 16'hfff0);
		run_line("stride_256", 333);
		rand_delay = 1'b1;
		run_line("rready_delay_a", 335);
		set_sprite(0, 0, 1, 1'b0, 0, 40, 479, 16'h1234);
		run_line("rready_delay_b", 335);
		run_line("clear_sprites", 337);
		write_reg(bus_pkg::TABLE_X, 0, '0);
		write_reg(bus_pkg::TABLE_X, 3, '0);
		write_reg(bus_pkg::TABLE_X, 255, '0);
		run_line("clear_blank_a", 337);
		run_line("clear_blank_b", 337);
		run_line("final_read", 337);

		if (n_checked == CHECKED_LINES * LINE_PIXELS) begin
			$display("=== PASS ===");
		end else begin
			$display("Only %0d of %0d pixels were compared", n_checked,
				CHECKED_LINES * LINE_PIXELS);
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
